// File: apu_pkg.sv
// APU shared definitions
// Lane count and latency, operation encoding and result flag layout
// used by the dispatcher, the lanes, the collector and the top level

package apu_pkg;

  // Number of identical arithmetic lanes, 2 or more
  localparam int NUM_LANES = 3;

  // Edges from accept to the lane's done cycle, 2 or more
  localparam int LANE_LAT = 5;

  // Operation code width
  localparam int APU_WOP = 3;

  // Result flag count
  localparam int APU_NUSFLAGS = 3;

  // Round-robin pointer width
  localparam int LANE_PTR_W = $clog2(NUM_LANES);

  // Supported operations
  // Codes 5 to 7 are undefined and return zero with no flags
  typedef enum logic [APU_WOP-1:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    // Low 32 bits of the product
    OP_MUL = 3'd2,
    // Signed compare
    OP_MIN = 3'd3,
    OP_MAX = 3'd4
  } apu_op_e;

  // Result flags
  // Bit 2 zero, bit 1 neg, bit 0 ovf
  typedef struct packed {
    // Result equals zero
    logic zero;
    // Bit 31 of the result
    logic neg;
    // Signed overflow, add and sub only
    logic ovf;
  } apu_flags_t;

endpackage

// File: apu_clock_gate.sv
// APU lane clock gate
// Latch based gate, enable sampled while the clock is low so the
// gated clock cannot glitch, scan override forces the clock on

`timescale 1ns/1ps

module apu_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic scan_cg_en_i,
  output logic clk_o
);

  // Enable held through the high phase
  logic en_latch;

  // Transparent while clock is low
  always_latch begin
    if (!clk_i) begin
      en_latch <= en_i | scan_cg_en_i;
    end
  end

  // Gated clock
  assign clk_o = clk_i & en_latch;

endmodule

// File: apu_delay_line.sv
// APU delay line
// Fixed number of register stages for any payload type,
// all stages cleared on reset

`timescale 1ns/1ps

module apu_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  payload_t data_i,
  output payload_t data_o
);

  // Stage 0 is the input side
  payload_t stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= data_i;
      // Shift towards the output
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

endmodule

// File: apu_dispatcher.sv
// APU request dispatcher
// Grants a core request when the lane under the round-robin pointer
// is free, starts that lane and broadcasts the operation and operands,
// also drives the enable of the lane clock gate

`timescale 1ns/1ps

module apu_dispatcher (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             apu_req_i,
  output logic                             apu_gnt_o,
  input  logic [apu_pkg::APU_WOP-1:0]      apu_op_i,
  input  logic [1:0][31:0]                 apu_operands_i,
  input  logic [apu_pkg::NUM_LANES-1:0]    lane_busy_i,
  output logic [apu_pkg::NUM_LANES-1:0]    lane_start_o,
  output logic [apu_pkg::APU_WOP-1:0]      lane_op_o,
  output logic [31:0]                      lane_a_o,
  output logic [31:0]                      lane_b_o,
  output logic                             lanes_active_o
);

  // Lane that takes the next request
  logic [apu_pkg::LANE_PTR_W-1:0] ptr_q;
  // Request taken this cycle
  logic                           accept;

  // Grant only depends on the pointed-to lane
  assign apu_gnt_o = !lane_busy_i[ptr_q];
  assign accept    = apu_req_i && apu_gnt_o;

  // One start bit, only in the accept cycle
  always_comb begin
    for (int i = 0; i < apu_pkg::NUM_LANES; i++) begin
      lane_start_o[i] = accept && (ptr_q == apu_pkg::LANE_PTR_W'(i));
    end
  end

  // Advance one lane per accept, wrap at the last lane
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;
    end else if (accept) begin
      if (ptr_q == apu_pkg::LANE_PTR_W'(apu_pkg::NUM_LANES - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // Broadcast to all lanes, only the started one samples it
  assign lane_op_o = apu_op_i;
  assign lane_a_o  = apu_operands_i[0];
  assign lane_b_o  = apu_operands_i[1];

  // Keep lane clock running while work is pending or in flight
  assign lanes_active_o = apu_req_i || (|lane_busy_i);

endmodule

// File: apu_lane.sv
// APU arithmetic lane
// Captures one operation on start, computes the 32-bit result and flags
// and returns them after a fixed latency of LANE_LAT edges

`timescale 1ns/1ps

module apu_lane (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        start_i,
  input  logic [apu_pkg::APU_WOP-1:0] op_i,
  input  logic [31:0]                 a_i,
  input  logic [31:0]                 b_i,
  output logic                        busy_o,
  output logic                        done_o,
  output logic [31:0]                 result_o,
  output apu_pkg::apu_flags_t         flags_o
);

  logic                        valid_q;
  logic                        busy_q;
  logic [apu_pkg::APU_WOP-1:0] op_q;
  logic [31:0]                 a_q;
  logic [31:0]                 b_q;
  logic [31:0]                 result_d;
  apu_pkg::apu_flags_t         flags_d;
  logic                        known_op;

  // Control state
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      valid_q <= start_i;
      if (start_i) begin
        busy_q <= 1'b1;
      end else if (done_o) begin
        // Free again on the edge that hands the result over
        busy_q <= 1'b0;
      end
    end
  end

  // Operation capture
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
    end
  end

  // Result and flags
  always_comb begin
    result_d = '0;
    flags_d  = '0;
    known_op = 1'b1;
    case (apu_pkg::apu_op_e'(op_q))
      apu_pkg::OP_ADD: begin
        result_d    = a_q + b_q;
        // Same operand signs, result sign differs
        flags_d.ovf = (a_q[31] == b_q[31]) && (result_d[31] != a_q[31]);
      end
      apu_pkg::OP_SUB: begin
        result_d    = a_q - b_q;
        // Operand signs differ, result takes the sign of b
        flags_d.ovf = (a_q[31] != b_q[31]) && (result_d[31] != a_q[31]);
      end
      apu_pkg::OP_MUL: result_d = a_q * b_q;
      apu_pkg::OP_MIN: result_d = ($signed(a_q) < $signed(b_q)) ? a_q : b_q;
      apu_pkg::OP_MAX: result_d = ($signed(a_q) > $signed(b_q)) ? a_q : b_q;
      default:         known_op = 1'b0;
    endcase
    // Undefined codes report no flags at all
    if (known_op) begin
      flags_d.zero = (result_d == '0);
      flags_d.neg  = result_d[31];
    end
  end

  // Remaining LANE_LAT-1 stages
  apu_delay_line #(
    .payload_t(logic [31:0]),
    .DEPTH    (apu_pkg::LANE_LAT - 1)
  ) i_result_dly (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (result_d),
    .data_o  (result_o)
  );

  apu_delay_line #(
    .payload_t(apu_pkg::apu_flags_t),
    .DEPTH    (apu_pkg::LANE_LAT - 1)
  ) i_flags_dly (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (flags_d),
    .data_o  (flags_o)
  );

  // Valid bit alongside, becomes done
  apu_delay_line #(
    .payload_t(logic),
    .DEPTH    (apu_pkg::LANE_LAT - 1)
  ) i_valid_dly (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (valid_q),
    .data_o  (done_o)
  );

  assign busy_o = busy_q;

endmodule

// File: apu_collector.sv
// APU result collector
// Picks the result of the lane that is done and registers it
// towards the core together with a single cycle rvalid strobe

`timescale 1ns/1ps

module apu_collector (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic [apu_pkg::NUM_LANES-1:0]        lane_done_i,
  input  logic [apu_pkg::NUM_LANES-1:0][31:0]  lane_result_i,
  input  apu_pkg::apu_flags_t [apu_pkg::NUM_LANES-1:0] lane_flags_i,
  output logic                                 apu_rvalid_o,
  output logic [31:0]                          apu_rdata_o,
  output apu_pkg::apu_flags_t                  apu_rflags_o
);

  logic [31:0]                     sel_result;
  logic [apu_pkg::APU_NUSFLAGS-1:0] sel_flags;
  logic                            any_done;

  // One-hot mux, at most one lane done per cycle
  always_comb begin
    sel_result = '0;
    sel_flags  = '0;
    for (int i = 0; i < apu_pkg::NUM_LANES; i++) begin
      if (lane_done_i[i]) begin
        sel_result = sel_result | lane_result_i[i];
        sel_flags  = sel_flags | lane_flags_i[i];
      end
    end
  end

  assign any_done = |lane_done_i;

  // Strobe, one cycle per done cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      apu_rvalid_o <= 1'b0;
    end else begin
      apu_rvalid_o <= any_done;
    end
  end

  // Result payload, held between results
  always_ff @(posedge clk_i) begin
    if (any_done) begin
      apu_rdata_o  <= sel_result;
      apu_rflags_o <= apu_pkg::apu_flags_t'(sel_flags);
    end
  end

endmodule

// File: apu_top.sv
// APU top level
// Dispatcher, gated bank of arithmetic lanes and result collector
// behind the core's req/gnt and rvalid strobes

`timescale 1ns/1ps

module apu_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        scan_cg_en_i,
  input  logic                        apu_req_i,
  output logic                        apu_gnt_o,
  input  logic [apu_pkg::APU_WOP-1:0] apu_op_i,
  input  logic [1:0][31:0]            apu_operands_i,
  output logic                        apu_rvalid_o,
  output logic [31:0]                 apu_rdata_o,
  output apu_pkg::apu_flags_t         apu_rflags_o
);

  // Gated lane clock
  logic                                        lane_clk;
  logic                                        lanes_active;

  // Dispatcher to lanes
  logic [apu_pkg::NUM_LANES-1:0]               lane_start;
  logic [apu_pkg::APU_WOP-1:0]                 lane_op;
  logic [31:0]                                 lane_a;
  logic [31:0]                                 lane_b;

  // Lanes back
  logic [apu_pkg::NUM_LANES-1:0]               lane_busy;
  logic [apu_pkg::NUM_LANES-1:0]               lane_done;
  logic [apu_pkg::NUM_LANES-1:0][31:0]         lane_result;
  apu_pkg::apu_flags_t [apu_pkg::NUM_LANES-1:0] lane_flags;

  apu_dispatcher i_dispatcher (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .apu_req_i     (apu_req_i),
    .apu_gnt_o     (apu_gnt_o),
    .apu_op_i      (apu_op_i),
    .apu_operands_i(apu_operands_i),
    .lane_busy_i   (lane_busy),
    .lane_start_o  (lane_start),
    .lane_op_o     (lane_op),
    .lane_a_o      (lane_a),
    .lane_b_o      (lane_b),
    .lanes_active_o(lanes_active)
  );

  // Lanes stop when nothing is requested or in flight
  apu_clock_gate i_clock_gate (
    .clk_i       (clk_i),
    .en_i        (lanes_active),
    .scan_cg_en_i(scan_cg_en_i),
    .clk_o       (lane_clk)
  );

  for (genvar i = 0; i < apu_pkg::NUM_LANES; i++) begin : gen_lanes
    apu_lane i_lane (
      .clk_i   (lane_clk),
      .arst_n_i(arst_n_i),
      .start_i (lane_start[i]),
      .op_i    (lane_op),
      .a_i     (lane_a),
      .b_i     (lane_b),
      .busy_o  (lane_busy[i]),
      .done_o  (lane_done[i]),
      .result_o(lane_result[i]),
      .flags_o (lane_flags[i])
    );
  end

  // Collector stays on the free running clock
  apu_collector i_collector (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lane_done_i  (lane_done),
    .lane_result_i(lane_result),
    .lane_flags_i (lane_flags),
    .apu_rvalid_o (apu_rvalid_o),
    .apu_rdata_o  (apu_rdata_o),
    .apu_rflags_o (apu_rflags_o)
  );

endmodule

// File: apu_top_assertions.sv
// APU handshake and lane assertions
// Bound into the top level, checks the result strobe width,
// lane exclusivity and request stability while waiting for a grant

`timescale 1ns/1ps

module apu_top_assertions (
  input logic                                clk_i,
  input logic                                arst_n_i,
  input logic                                apu_req_i,
  input logic                                apu_gnt_i,
  input logic [apu_pkg::APU_WOP-1:0]         apu_op_i,
  input logic [1:0][31:0]                    apu_operands_i,
  input logic                                apu_rvalid_i,
  input logic [apu_pkg::NUM_LANES-1:0]       lane_start_i,
  input logic [apu_pkg::NUM_LANES-1:0]       lane_busy_i,
  input logic [apu_pkg::NUM_LANES-1:0]       lane_done_i
);

  // Failed assertions so far, read by the testbench
  int fail_cnt = 0;

  // One strobe cycle per result, back-to-back strobes come from different lanes
  a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (apu_rvalid_i && $past(apu_rvalid_i)) |-> ($past(lane_done_i) != $past(lane_done_i, 2)))
  else begin
    fail_cnt++;
    $error("apu_rvalid_o high for two cycles in a row for one result");
  end

  // Lanes finish one at a time
  a_done_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(lane_done_i))
  else begin
    fail_cnt++;
    $error("more than one lane done in the same cycle");
  end

  // A started lane is still busy, and not started again, LANE_LAT cycles later
  a_start_free: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(|($past(lane_start_i, apu_pkg::LANE_LAT) & (lane_start_i | ~lane_busy_i))))
  else begin
    fail_cnt++;
    $error("start pulse sent to a busy lane or lane freed before its latency");
  end

  // Waiting request keeps its payload
  a_req_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (apu_req_i && !apu_gnt_i) |=> ($stable(apu_op_i) && $stable(apu_operands_i)))
  else begin
    fail_cnt++;
    $error("operands changed while the request waited for a grant");
  end

endmodule

// File: tb_clk_gen.sv
// Testbench clock and reset
// 4 ns clock, reset held low for the first 8 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  // Release just after an edge, like the other inputs
  initial begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// File: tb_apu_top.sv
// APU testbench top
// Replays directed vectors, then random back-to-back and gapped streams,
// checking every result, its flags and its latency against a model

`timescale 1ns/1ps

module tb_apu_top;

  localparam int NUM_VEC = 21;
  localparam int TIMEOUT = 100;

  logic                          clk;
  logic                          arst_n;
  logic                          scan_cg_en;
  logic                          req;
  logic                          gnt;
  logic [apu_pkg::APU_WOP-1:0]   op;
  logic [1:0][31:0]              operands;
  logic                          rvalid;
  logic [31:0]                   rdata;
  apu_pkg::apu_flags_t           rflags;

  // Five words per vector line
  logic [31:0] vec_mem [0:5*NUM_VEC-1];
  // Expected {data, flags} and accept cycle, in accept order
  logic [34:0] exp_q [$];
  int          acc_cycle_q [$];
  logic [34:0] exp_val;
  int          lat;
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          base_checks;
  int          base_errors;
  int          gnt_drops;
  int          asrt_fails;
  integer      seed;
  string       test_name;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  apu_top i_dut (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .scan_cg_en_i  (scan_cg_en),
    .apu_req_i     (req),
    .apu_gnt_o     (gnt),
    .apu_op_i      (op),
    .apu_operands_i(operands),
    .apu_rvalid_o  (rvalid),
    .apu_rdata_o   (rdata),
    .apu_rflags_o  (rflags)
  );

  bind apu_top apu_top_assertions i_assertions (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .apu_req_i     (apu_req_i),
    .apu_gnt_i     (apu_gnt_o),
    .apu_op_i      (apu_op_i),
    .apu_operands_i(apu_operands_i),
    .apu_rvalid_i  (apu_rvalid_o),
    .lane_start_i  (lane_start),
    .lane_busy_i   (lane_busy),
    .lane_done_i   (lane_done)
  );

  // Reference model, returns {result, zero, neg, ovf}
  function automatic logic [34:0] model(input logic [2:0] o, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [32:0] wide;
    logic [31:0] r;
    logic        v;
    wide = '0;
    r    = '0;
    v    = 1'b0;
    case (o)
      apu_pkg::OP_ADD: begin
        // Sign extended sum, overflow when the top two bits differ
        wide = {a[31], a} + {b[31], b};
        r    = wide[31:0];
        v    = wide[32] ^ wide[31];
      end
      apu_pkg::OP_SUB: begin
        wide = {a[31], a} - {b[31], b};
        r    = wide[31:0];
        v    = wide[32] ^ wide[31];
      end
      apu_pkg::OP_MUL: r = a * b;
      apu_pkg::OP_MIN: r = ($signed(a) <= $signed(b)) ? a : b;
      apu_pkg::OP_MAX: r = ($signed(a) >= $signed(b)) ? a : b;
      default: return '0;
    endcase
    return {r, (r == 32'd0), r[31], v};
  endfunction

  // Count rising edges, read at falling edges
  always @(posedge clk) begin
    cycle++;
  end

  // Result check at each strobe, sampled mid cycle
  always @(negedge clk) begin
    if (arst_n && rvalid) begin
      if (exp_q.size() == 0) begin
        $display("result returned with no request pending in test %s", test_name);
        errors++;
      end else begin
        exp_val = exp_q.pop_front();
        lat     = cycle - acc_cycle_q.pop_front();
        checks++;
        if ({rdata, rflags} !== exp_val) begin
          $display("mismatch %s: expected %h flags %b, actual %h flags %b", test_name,
                   exp_val[34:3], exp_val[2:0], rdata, rflags);
          errors++;
        end
        if (lat != apu_pkg::LANE_LAT + 1) begin
          $display("mismatch %s latency: expected %0d, actual %0d", test_name,
                   apu_pkg::LANE_LAT + 1, lat);
          errors++;
        end
      end
    end
  end

  task automatic start_test(input string name);
    test_name   = name;
    base_checks = checks;
    base_errors = errors;
  endtask

  task automatic end_test();
    $display("test %s: %0d results, %0d errors", test_name, checks - base_checks,
             errors - base_errors);
  endtask

  // Present one request at 1 ns past the edge, hold it until granted
  task automatic issue(input logic [2:0] o, input logic [31:0] a, input logic [31:0] b,
                       input logic [34:0] exp_res);
    int waited;
    waited      = 0;
    req         = 1'b1;
    op          = o;
    operands[0] = a;
    operands[1] = b;
    @(negedge clk);
    while (!gnt && waited < TIMEOUT) begin
      gnt_drops++;
      waited++;
      @(negedge clk);
    end
    if (gnt) begin
      exp_q.push_back(exp_res);
      acc_cycle_q.push_back(cycle);
    end else begin
      $display("request not granted within timeout in test %s", test_name);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  // Wait for every outstanding result
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("no result within timeout in test %s, %0d requests lost", test_name,
               exp_q.size());
      errors++;
      exp_q.delete();
      acc_cycle_q.delete();
    end
    @(posedge clk);
    #1;
  endtask

  // One request at a time, so each is isolated
  task automatic replay_vectors();
    for (int i = 0; i < NUM_VEC; i++) begin
      issue(vec_mem[5*i][2:0], vec_mem[5*i+1], vec_mem[5*i+2],
            {vec_mem[5*i+3], vec_mem[5*i+4][2:0]});
      req = 1'b0;
      drain();
    end
  endtask

  // Random ops and operands, idle gaps of 0 to 9 cycles when enabled
  task automatic random_stream(input int count, input bit gaps);
    logic [31:0] r_op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r_gap;
    for (int n = 0; n < count; n++) begin
      r_op  = $random(seed);
      a     = $random(seed);
      b     = $random(seed);
      r_gap = $random(seed);
      issue(r_op[2:0], a, b, model(r_op[2:0], a, b));
      if (gaps && (r_gap[3:0] % 10) != 0) begin
        req = 1'b0;
        repeat (r_gap[3:0] % 10) @(posedge clk);
        #1;
      end
    end
    req = 1'b0;
    drain();
    if (checks - base_checks != count) begin
      $display("test %s returned %0d of %0d results", test_name, checks - base_checks, count);
      errors++;
    end
  endtask

  initial begin
    int waited;
    waited      = 0;
    seed        = 32'haa8e_9f40;
    scan_cg_en  = 1'b0;
    req         = 1'b0;
    op          = '0;
    operands    = '0;
    $readmemh("apu_vectors.txt", vec_mem);

    start_test("reset");
    while (!arst_n && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    @(negedge clk);
    checks++;
    if (!arst_n) begin
      $display("reset never released");
      errors++;
    end
    if (rvalid !== 1'b0 || gnt !== 1'b1) begin
      $display("mismatch reset: expected rvalid 0 gnt 1, actual rvalid %b gnt %b", rvalid, gnt);
      errors++;
    end
    end_test();
    @(posedge clk);
    #1;

    start_test("vectors");
    replay_vectors();
    end_test();

    start_test("back_to_back");
    gnt_drops = 0;
    random_stream(40, 1'b0);
    if (gnt_drops == 0) begin
      $display("grant never dropped during the back-to-back stream");
      errors++;
    end
    end_test();

    start_test("random_gaps");
    random_stream(40, 1'b1);
    end_test();

    // Lane clock forced on
    start_test("scan_vectors");
    scan_cg_en = 1'b1;
    replay_vectors();
    scan_cg_en = 1'b0;
    end_test();

    asrt_fails = i_dut.i_assertions.fail_cnt;
    $display("results checked %0d, errors %0d, assertion failures %0d", checks, errors,
             asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: apu_top.f
apu_pkg.sv
apu_clock_gate.sv
apu_delay_line.sv
apu_dispatcher.sv
apu_lane.sv
apu_collector.sv
apu_top.sv
apu_top_assertions.sv
tb_clk_gen.sv
tb_apu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the APU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_apu_top -f apu_top.f

status=0
./obj_dir/Vtb_apu_top +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
exit "$status"

// File: apu_vectors.txt
// op a b result flags, all hex, flags bit 2 zero, bit 1 neg, bit 0 ovf
// op 0 add, 1 sub, 2 mul, 3 min, 4 max, 5 to 7 undefined
0 00000001 00000002 00000003 0
0 00000000 00000000 00000000 4
0 7fffffff 00000001 80000000 3
0 80000000 80000000 00000000 5
0 fffffffe ffffffff fffffffd 2
1 00000005 00000003 00000002 0
1 80000000 00000001 7fffffff 1
1 7fffffff ffffffff 80000000 3
1 12345678 12345678 00000000 4
2 00000006 00000007 0000002a 0
2 ffffffff 00000002 fffffffe 2
2 00010000 00010000 00000000 4
2 00001234 00005678 06260060 0
3 00000005 fffffffb fffffffb 2
3 80000000 7fffffff 80000000 2
3 00000010 00000020 00000010 0
4 00000005 fffffffb 00000005 0
4 80000000 7fffffff 7fffffff 0
4 00000000 ffffffff 00000000 4
5 12345678 9abcdef0 00000000 0
7 ffffffff ffffffff 00000000 0
